// File: Makefile
VERILATOR ?= verilator
TOP       := registerFileTb
FILELIST  := registerFile.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
PASS_TEXT := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: design/dataPathPkg.sv
`default_nettype none

`include "registerFile_params.svh"

package dataPathPkg;

	typedef logic [`REG_WIDTH-1:0] regWord_t; // one register value.

	// port A register select.
	typedef enum logic [1:0] {
		aAddrArg = 2'd0, // instruction argument.
		aAddrRa  = 2'd1,
		aAddrRb  = 2'd2,
		aAddrRl  = 2'd3
	} regAAddrSel_t;

	// port A write data source.
	typedef enum logic [1:0] {
		aDinDin  = 2'd0, // memory data in.
		aDinByte = 2'd1, // one byte of din, zero extended.
		aDinHere = 2'd2, // dictionary pointer.
		aDinAluR = 2'd3
	} regADinSel_t;

	typedef enum logic {
		aByteLow  = 1'b0,
		aByteHigh = 1'b1
	} regAByteSel_t;

endpackage

`default_nettype wire

// File: design/regFilePkg.sv
`default_nettype none

`include "registerFile_params.svh"

package regFilePkg;

	typedef logic [`REG_ADDR_W-1:0] regNum_t; // one register number.

	// registers with fixed roles.
	localparam regNum_t R1  = 4'd1;  // scratch.
	localparam regNum_t RA  = 4'd10; // return address.
	localparam regNum_t RB  = 4'd11; // scratch.
	localparam regNum_t RL  = 4'd12; // loop.
	localparam regNum_t RSP = 4'd13; // stack pointer.
	localparam regNum_t RFP = 4'd14; // frame pointer.
	localparam regNum_t RRS = 4'd15; // return stack.

	// port B register select, all writes come from the ALU.
	typedef enum logic [2:0] {
		bAddrArg = 3'd0, // instruction argument.
		bAddrRb  = 3'd1,
		bAddrRsp = 3'd2,
		bAddrRfp = 3'd3,
		bAddrRrs = 3'd4
	} regBAddrSel_t;

endpackage

`default_nettype wire

// File: design/regPortDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "registerFile_params.svh"

module regPortDecode (
	input  regFilePkg::regNum_t       argA,
	input  dataPathPkg::regAAddrSel_t regAAddrSel,
	input  regFilePkg::regNum_t       argB,
	input  regFilePkg::regBAddrSel_t  regBAddrSel,
	input  dataPathPkg::regADinSel_t  regADinSel,
	input  dataPathPkg::regAByteSel_t regAByteSel,
	input  dataPathPkg::regWord_t     din,
	input  dataPathPkg::regWord_t     here,
	input  dataPathPkg::regWord_t     aluR,
	output regFilePkg::regNum_t       addrA,
	output regFilePkg::regNum_t       addrB,
	output dataPathPkg::regWord_t     wdataA
);

	import regFilePkg::*;
	import dataPathPkg::*;

	localparam int HALF = `REG_WIDTH / 2;

	logic [HALF-1:0] byteVal; // byte picked out of din.

	// port A register number.
	always_comb begin
		case (regAAddrSel)
			aAddrRa: addrA = RA;
			aAddrRb: addrA = RB;
			aAddrRl: addrA = RL;
			default: addrA = argA; // argument select.
		endcase
	end

	// port B register number, unused codes fall back to the argument.
	always_comb begin
		case (regBAddrSel)
			bAddrRb:  addrB = RB;
			bAddrRsp: addrB = RSP;
			bAddrRfp: addrB = RFP;
			bAddrRrs: addrB = RRS;
			default:  addrB = argB;
		endcase
	end

	assign byteVal = (regAByteSel == aByteHigh) ? din[`REG_WIDTH-1:HALF] : din[HALF-1:0];

	// port A write word.
	always_comb begin
		case (regADinSel)
			aDinByte: wdataA = {{HALF{1'b0}}, byteVal}; // zero extend.
			aDinHere: wdataA = here;
			aDinAluR: wdataA = aluR;
			default:  wdataA = din;
		endcase
	end

endmodule

`default_nettype wire

// File: design/regStorage.sv
`timescale 1ns/1ps
`default_nettype none

`include "registerFile_params.svh"

module regStorage (
	input  logic                  CLK,
	input  logic                  arstN,
	input  logic                  enA,
	input  logic                  enB,
	input  regFilePkg::regNum_t   addrA,
	input  regFilePkg::regNum_t   addrB,
	input  dataPathPkg::regWord_t wdataA,
	input  dataPathPkg::regWord_t wdataB,
	input  logic [1:0]            grantA,
	input  logic [1:0]            grantB,
	output dataPathPkg::regWord_t doutA,
	output dataPathPkg::regWord_t doutB
);

	import dataPathPkg::*;

	localparam int LANES = `REG_WIDTH / 8;

	regWord_t regs     [`REG_COUNT]; // the register file.
	regWord_t nextRegs [`REG_COUNT]; // contents after this edge's writes.

	// merge granted lanes into each register.
	always_comb begin
		for (int r = 0; r < `REG_COUNT; r++) begin
			nextRegs[r] = regs[r];
			for (int l = 0; l < LANES; l++) begin
				if (grantB[l] && (addrB == `REG_ADDR_W'(r))) begin
					nextRegs[r][l*8 +: 8] = wdataB[l*8 +: 8];
				end else if (grantA[l] && (addrA == `REG_ADDR_W'(r))) begin
					nextRegs[r][l*8 +: 8] = wdataA[l*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int r = 0; r < `REG_COUNT; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int r = 0; r < `REG_COUNT; r++) begin
				regs[r] <= nextRegs[r];
			end
		end
	end

	// registered reads see this edge's write.
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			doutA <= '0;
			doutB <= '0;
		end else begin
			if (enA) begin
				doutA <= nextRegs[addrA];
			end
			if (enB) begin
				doutB <= nextRegs[addrB];
			end
		end
	end

	assertResetOut: assert property (@(posedge CLK) !arstN |-> (doutA == '0 && doutB == '0))
		else $error("read port not cleared in reset");

	assertAddrAKnown: assert property (@(posedge CLK) disable iff (!arstN)
		enA |-> !$isunknown(addrA))
		else $error("port A enabled with unknown address");

	assertAddrBKnown: assert property (@(posedge CLK) disable iff (!arstN)
		enB |-> !$isunknown(addrB))
		else $error("port B enabled with unknown address");

endmodule

`default_nettype wire

// File: design/regWriteArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module regWriteArbiter (
	input  regFilePkg::regNum_t addrA,
	input  regFilePkg::regNum_t addrB,
	input  logic                wenA,
	input  logic                wenB,
	input  logic [1:0]          byteEnA,
	input  logic [1:0]          byteEnB,
	output logic [1:0]          grantA,
	output logic [1:0]          grantB
);

	logic       sameReg;  // both ports write one register.
	logic [1:0] lostA;    // lanes port B takes from port A.

	assign sameReg = wenA && wenB && (addrA == addrB);
	assign lostA   = sameReg ? byteEnB : 2'b00;

	// port B always wins a shared lane.
	assign grantB = wenB ? byteEnB : 2'b00;
	assign grantA = wenA ? (byteEnA & ~lostA) : 2'b00;

endmodule

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic                      CLK,
	input  logic                      arstN,
	input  dataPathPkg::regWord_t     aluR,
	input  dataPathPkg::regWord_t     din,
	input  dataPathPkg::regWord_t     here,
	input  logic                      regAEn,
	input  logic                      regAWen,
	input  regFilePkg::regNum_t       argA,
	input  dataPathPkg::regAAddrSel_t regAAddrSel,
	input  dataPathPkg::regADinSel_t  regADinSel,
	input  dataPathPkg::regAByteSel_t regAByteSel,
	input  logic [1:0]                regAByteEn,
	input  logic                      regBEn,
	input  logic                      regBWen,
	input  regFilePkg::regNum_t       argB,
	input  regFilePkg::regBAddrSel_t  regBAddrSel,
	input  logic [1:0]                regBByteEn,
	output dataPathPkg::regWord_t     regADout,
	output dataPathPkg::regWord_t     regBDout
);

	import regFilePkg::*;
	import dataPathPkg::*;

	regNum_t    addrA;
	regNum_t    addrB;
	regWord_t   wdataA; // port A write word after source select.
	logic       wrA;
	logic       wrB;
	logic [1:0] grantA;
	logic [1:0] grantB;

	assign wrA = regAEn & regAWen; // write needs the port enabled.
	assign wrB = regBEn & regBWen;

	regPortDecode u_regPortDecode (
		.argA(argA), .regAAddrSel(regAAddrSel),
		.argB(argB), .regBAddrSel(regBAddrSel),
		.regADinSel(regADinSel), .regAByteSel(regAByteSel),
		.din(din), .here(here), .aluR(aluR),
		.addrA(addrA), .addrB(addrB), .wdataA(wdataA)
	);

	regWriteArbiter u_regWriteArbiter (
		.addrA(addrA), .addrB(addrB), .wenA(wrA), .wenB(wrB),
		.byteEnA(regAByteEn), .byteEnB(regBByteEn),
		.grantA(grantA), .grantB(grantB)
	);

	regStorage u_regStorage (
		.CLK(CLK), .arstN(arstN), .enA(regAEn), .enB(regBEn),
		.addrA(addrA), .addrB(addrB),
		.wdataA(wdataA), .wdataB(aluR), // port B always writes the ALU result.
		.grantA(grantA), .grantB(grantB),
		.doutA(regADout), .doutB(regBDout)
	);

endmodule

`default_nettype wire

// File: design/registerFile_params.svh
`ifndef REGISTERFILE_PARAMS_SVH
`define REGISTERFILE_PARAMS_SVH

`define REG_WIDTH 16 // bits per register.
`define REG_COUNT 16 // registers in the file.
`define REG_ADDR_W 4 // bits in a register number.

`endif

// File: registerFile.f
+incdir+design
design/dataPathPkg.sv
design/regFilePkg.sv
design/regPortDecode.sv
design/regWriteArbiter.sv
design/regStorage.sv
design/registerFile.sv
verif/regFileModel.sv
verif/registerFileTb.sv

// File: verif/regFileModel.sv
`timescale 1ns/1ps
`default_nettype none

module regFileModel (
	input  logic        CLK,
	input  logic        arstN,
	input  logic [15:0] aluR,
	input  logic [15:0] din,
	input  logic [15:0] here,
	input  logic        regAEn,
	input  logic        regAWen,
	input  logic [3:0]  argA,
	input  logic [1:0]  regAAddrSel,
	input  logic [1:0]  regADinSel,
	input  logic        regAByteSel,
	input  logic [1:0]  regAByteEn,
	input  logic        regBEn,
	input  logic        regBWen,
	input  logic [3:0]  argB,
	input  logic [2:0]  regBAddrSel,
	input  logic [1:0]  regBByteEn,
	output logic [15:0] expA,
	output logic [15:0] expB
);

	logic [15:0] mem    [16];
	logic [15:0] shadow [16]; // contents once this edge's writes land.
	logic [3:0]  numA;
	logic [3:0]  numB;
	logic [15:0] wordA;

	function automatic logic [3:0] portANum(input logic [1:0] sel, input logic [3:0] arg);
		case (sel)
			2'd1: return 4'd10; // return address.
			2'd2: return 4'd11;
			2'd3: return 4'd12; // loop.
			default: return arg;
		endcase
	endfunction

	function automatic logic [3:0] portBNum(input logic [2:0] sel, input logic [3:0] arg);
		case (sel)
			3'd1: return 4'd11;
			3'd2: return 4'd13; // stack pointer.
			3'd3: return 4'd14; // frame pointer.
			3'd4: return 4'd15; // return stack.
			default: return arg;
		endcase
	endfunction

	function automatic logic [15:0] portAWord(input logic [1:0] src, input logic hi);
		case (src)
			2'd1: return {8'h00, hi ? din[15:8] : din[7:0]};
			2'd2: return here;
			2'd3: return aluR;
			default: return din;
		endcase
	endfunction

	always @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 16; i++) mem[i] <= 16'h0000;
			expA <= 16'h0000;
			expB <= 16'h0000;
		end else begin
			numA = portANum(regAAddrSel, argA);
			numB = portBNum(regBAddrSel, argB);
			wordA = portAWord(regADinSel, regAByteSel);
			for (int i = 0; i < 16; i++) shadow[i] = mem[i];
			// port A lands first, so port B's bytes win a shared lane.
			for (int l = 0; l < 2; l++) begin
				if (regAEn && regAWen && regAByteEn[l]) shadow[numA][8*l +: 8] = wordA[8*l +: 8];
			end
			for (int l = 0; l < 2; l++) begin
				if (regBEn && regBWen && regBByteEn[l]) shadow[numB][8*l +: 8] = aluR[8*l +: 8];
			end
			for (int i = 0; i < 16; i++) mem[i] <= shadow[i];
			if (regAEn) expA <= shadow[numA]; // write-first read.
			if (regBEn) expB <= shadow[numB];
		end
	end

endmodule

`default_nettype wire

// File: verif/registerFileTb.sv
`timescale 1ns/1ps
`default_nettype none

module registerFileTb;

	import regFilePkg::*;
	import dataPathPkg::*;

	localparam int RANDOM_CYCLES = 2000;
	localparam int MAX_CYCLES    = 3 * RANDOM_CYCLES; // random run plus directed tests, with margin.

	logic         CLK;
	logic         arstN;
	regWord_t     aluR;
	regWord_t     din;
	regWord_t     here;
	logic         regAEn;
	logic         regAWen;
	regNum_t      argA;
	regAAddrSel_t regAAddrSel;
	regADinSel_t  regADinSel;
	regAByteSel_t regAByteSel;
	logic [1:0]   regAByteEn;
	logic         regBEn;
	logic         regBWen;
	regNum_t      argB;
	regBAddrSel_t regBAddrSel;
	logic [1:0]   regBByteEn;
	regWord_t     regADout;
	regWord_t     regBDout;
	regWord_t     expA;
	regWord_t     expB;
	int           errors = 0;
	int           errorsBefore = 0;
	int           tests = 0;
	int           failedTests = 0;
	int           cycles = 0;
	bit           checking = 0; // model compare on once reset is released.

	registerFile u_registerFile (.*);
	regFileModel u_regFileModel (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic checkVal(input regWord_t got, input regWord_t want, input string what);
		if (got !== want) begin
			errors++;
			$display("Error at %0t ns: %s read %h, expected %h", $time, what, got, want);
		end
	endtask

	// both ports against the model, every cycle.
	always @(negedge CLK) begin
		if (checking) begin
			checkVal(regADout, expA, "port A against model");
			checkVal(regBDout, expB, "port B against model");
		end
	end

	task automatic clearEnables();
		regAEn  <= 1'b0;
		regAWen <= 1'b0;
		regBEn  <= 1'b0;
		regBWen <= 1'b0;
	endtask

	task automatic driveA(input regAAddrSel_t sel, input regNum_t arg, input logic wen,
		input regADinSel_t src, input regAByteSel_t bsel, input logic [1:0] be);
		regAEn      <= 1'b1;
		regAWen     <= wen;
		regAAddrSel <= sel;
		argA        <= arg;
		regADinSel  <= src;
		regAByteSel <= bsel;
		regAByteEn  <= be;
	endtask

	task automatic driveB(input regBAddrSel_t sel, input regNum_t arg, input logic wen,
		input logic [1:0] be);
		regBEn      <= 1'b1;
		regBWen     <= wen;
		regBAddrSel <= sel;
		argB        <= arg;
		regBByteEn  <= be;
	endtask

	// let the driven edge pass, then settle mid cycle.
	task automatic finishEdge();
		@(posedge CLK);
		clearEnables();
		@(negedge CLK);
	endtask

	task automatic writeA(input regAAddrSel_t sel, input regNum_t arg, input regADinSel_t src,
		input regAByteSel_t bsel, input logic [1:0] be, input regWord_t d, input regWord_t want,
		input string what);
		@(posedge CLK);
		din <= d;
		driveA(sel, arg, 1'b1, src, bsel, be);
		finishEdge();
		checkVal(regADout, want, what);
	endtask

	task automatic writeB(input regBAddrSel_t sel, input regNum_t arg, input logic [1:0] be,
		input regWord_t val, input regWord_t want, input string what);
		@(posedge CLK);
		aluR <= val;
		driveB(sel, arg, 1'b1, be);
		finishEdge();
		checkVal(regBDout, want, what);
	endtask

	task automatic readA(input regNum_t num, input regWord_t want, input string what);
		@(posedge CLK);
		driveA(aAddrArg, num, 1'b0, aDinDin, aByteLow, 2'b00);
		finishEdge();
		checkVal(regADout, want, what);
	endtask

	task automatic endTest(input string name);
		tests++;
		if (errors != errorsBefore) begin
			failedTests++;
			$display("test %s: FAILED", name);
		end else begin
			$display("test %s: ok", name);
		end
		errorsBefore = errors;
	endtask

	initial begin
		void'($urandom(59));
		arstN = 1'b1;
		aluR = '0;
		din = '0;
		here = '0;
		regAEn = 1'b0;
		regAWen = 1'b0;
		argA = '0;
		regAAddrSel = aAddrArg;
		regADinSel = aDinDin;
		regAByteSel = aByteLow;
		regAByteEn = 2'b00;
		regBEn = 1'b0;
		regBWen = 1'b0;
		argB = '0;
		regBAddrSel = bAddrArg;
		regBByteEn = 2'b00;
		#1 arstN = 1'b0;
		repeat (16) @(posedge CLK);
		arstN <= 1'b1;
		checking = 1'b1;
		@(negedge CLK);

		checkVal(regADout, 16'h0000, "port A after reset");
		checkVal(regBDout, 16'h0000, "port B after reset");
		for (int i = 0; i < 16; i++) readA(regNum_t'(i), 16'h0000, $sformatf("reset r%0d", i));
		endTest("reset");

		@(posedge CLK);
		here <= 16'h1234;
		aluR <= 16'h0F0F;
		writeA(aAddrArg, 4'd2, aDinDin, aByteLow, 2'b11, 16'hA5C3, 16'hA5C3, "din to r2");
		writeA(aAddrRa, 4'd0, aDinByte, aByteLow, 2'b11, 16'hA5C3, 16'h00C3, "low byte to RA");
		writeA(aAddrRb, 4'd0, aDinByte, aByteHigh, 2'b11, 16'hA5C3, 16'h00A5, "high byte to RB");
		writeA(aAddrRl, 4'd0, aDinHere, aByteLow, 2'b11, 16'hFFFF, 16'h1234, "here to RL");
		writeA(aAddrArg, 4'd3, aDinAluR, aByteLow, 2'b11, 16'hFFFF, 16'h0F0F, "aluR to r3");
		readA(4'd2, 16'hA5C3, "r2 read back");
		readA(4'd10, 16'h00C3, "r10 read back");
		readA(4'd11, 16'h00A5, "r11 read back");
		readA(4'd12, 16'h1234, "r12 read back");
		readA(4'd3, 16'h0F0F, "r3 read back");
		@(posedge CLK);
		driveA(aAddrRl, 4'd0, 1'b0, aDinDin, aByteLow, 2'b00);
		finishEdge();
		checkVal(regADout, 16'h1234, "RL read by role");
		endTest("port A sources");

		writeB(bAddrArg, 4'd5, 2'b11, 16'h5555, 16'h5555, "aluR to r5");
		writeB(bAddrRb, 4'd0, 2'b11, 16'hB0B0, 16'hB0B0, "aluR to RB");
		writeB(bAddrRsp, 4'd0, 2'b11, 16'h5D5D, 16'h5D5D, "aluR to RSP");
		writeB(bAddrRfp, 4'd0, 2'b11, 16'hF0F0, 16'hF0F0, "aluR to RFP");
		writeB(bAddrRrs, 4'd0, 2'b11, 16'hE5E5, 16'hE5E5, "aluR to RRS");
		readA(4'd5, 16'h5555, "r5 read back");
		readA(4'd11, 16'hB0B0, "r11 read back");
		readA(4'd13, 16'h5D5D, "r13 read back");
		readA(4'd14, 16'hF0F0, "r14 read back");
		readA(4'd15, 16'hE5E5, "r15 read back");
		endTest("port B addressing");

		writeA(aAddrArg, 4'd4, aDinDin, aByteLow, 2'b11, 16'hAABB, 16'hAABB, "r4 full");
		writeA(aAddrArg, 4'd4, aDinDin, aByteLow, 2'b01, 16'h1234, 16'hAA34, "r4 low lane");
		writeA(aAddrArg, 4'd4, aDinDin, aByteLow, 2'b10, 16'h5678, 16'h5634, "r4 high lane");
		writeB(bAddrArg, 4'd4, 2'b10, 16'h9900, 16'h9934, "r4 high lane from B");
		readA(4'd4, 16'h9934, "r4 read back");
		// the idle port still points at r4 while the other port rewrites it.
		writeB(bAddrArg, 4'd4, 2'b11, 16'hCAFE, 16'hCAFE, "r4 full from B");
		checkVal(regADout, 16'h9934, "port A hold");
		writeA(aAddrArg, 4'd4, aDinDin, aByteLow, 2'b11, 16'h7777, 16'h7777, "r4 full from A");
		checkVal(regBDout, 16'hCAFE, "port B hold");
		endTest("byte enables and hold");

		@(posedge CLK);
		din <= 16'h1122;
		aluR <= 16'h3344;
		driveA(aAddrArg, 4'd8, 1'b1, aDinDin, aByteLow, 2'b11);
		driveB(bAddrArg, 4'd8, 1'b1, 2'b10);
		finishEdge();
		checkVal(regADout, 16'h3322, "r8 collision on port A");
		checkVal(regBDout, 16'h3322, "r8 collision on port B");
		@(posedge CLK);
		din <= 16'h5566;
		aluR <= 16'h7788;
		driveA(aAddrRb, 4'd0, 1'b1, aDinDin, aByteLow, 2'b01);
		driveB(bAddrRb, 4'd0, 1'b1, 2'b01);
		finishEdge();
		checkVal(regBDout, 16'hB088, "RB collision on port B");
		readA(4'd8, 16'h3322, "r8 read back");
		readA(4'd11, 16'hB088, "r11 read back");
		endTest("collisions");

		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			@(posedge CLK);
			aluR <= regWord_t'($urandom);
			din <= regWord_t'($urandom);
			here <= regWord_t'($urandom);
			regAEn <= 1'($urandom);
			regAWen <= 1'($urandom);
			argA <= regNum_t'($urandom);
			regAAddrSel <= regAAddrSel_t'($urandom_range(0, 3));
			regADinSel <= regADinSel_t'($urandom_range(0, 3));
			regAByteSel <= regAByteSel_t'($urandom_range(0, 1));
			regAByteEn <= 2'($urandom);
			regBEn <= 1'($urandom);
			regBWen <= 1'($urandom);
			argB <= regNum_t'($urandom);
			regBAddrSel <= regBAddrSel_t'($urandom_range(0, 7)); // spare codes fall back to argB.
			regBByteEn <= 2'($urandom);
		end
		finishEdge();
		endTest("random traffic");

		$display("tests run %0d, tests failed %0d, errors %0d", tests, failedTests, errors);
		if (errors == 0 && failedTests == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
